// File: logic/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// instruction memory word-address width
`define IMEM_AW 6
// data memory word-address width
`define DMEM_AW 6
`define NUM_REGS 32

`endif

// File: logic/mips_pkg.sv
package mips_pkg;

  typedef enum logic [5:0] {
    SPECIAL = 6'h00,
    J       = 6'h02,
    JAL     = 6'h03,
    BEQ     = 6'h04,
    BNE     = 6'h05,
    ADDI    = 6'h08,
    ADDIU   = 6'h09,
    ORI     = 6'h0d,
    LUI     = 6'h0f,
    LW      = 6'h23,
    SW      = 6'h2b
  } opcode_e;

  // funct field, only meaningful under SPECIAL
  typedef enum logic [5:0] {
    FN_JR  = 6'h08,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    BCU_NONE,
    BCU_EQ,
    BCU_NE
  } bcu_op_e;

  typedef enum logic [1:0] {
    JMP_NONE,
    JMP_IMM,
    JMP_REG
  } jump_e;

  typedef struct packed {
    opcode_e    op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_e     funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_e     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    opcode_e     op;
    logic [25:0] target;
  } j_fmt_t;

  // one fetched word, viewed in any of the three formats
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage

// File: logic/ctrl_if.sv
interface ctrl_if;
  import mips_pkg::*;

  logic    reg_write;
  logic    reg_dst;
  logic    jal;
  logic    mem_to_reg;
  logic    mem_write;
  logic    alu_src;
  alu_op_e alu_op;
  logic    load_upper;
  logic    zero_ext;
  jump_e   jump;
  bcu_op_e bcu_op;

  modport control (
    output reg_write, reg_dst, jal, mem_to_reg, mem_write, alu_src,
    output alu_op, load_upper, zero_ext, jump, bcu_op
  );

  modport fetch (input jump, jal, bcu_op);

  // jal also steers the link register and write data
  modport exec (
    input reg_write, reg_dst, jal, mem_to_reg, mem_write, alu_src,
    input alu_op, load_upper, zero_ext
  );

endinterface

// File: logic/control_unit.sv
module control_unit (
  input mips_pkg::instr_t instr,
  ctrl_if.control         ctl
);
  import mips_pkg::*;

  logic op_ok;
  logic fn_ok;

  always_comb begin
    // supported funct codes
    case (instr.r_fmt.funct)
      FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_JR: fn_ok = 1'b1;
      default: fn_ok = 1'b0;
    endcase

    // supported opcodes
    case (instr.r_fmt.op)
      SPECIAL: op_ok = fn_ok;
      J, JAL, BEQ, BNE, ADDI, ADDIU, ORI, LW, SW, LUI: op_ok = 1'b1;
      default: op_ok = 1'b0;
    endcase

    ctl.jal = (instr.j_fmt.op == JAL);

    case (instr.r_fmt.op)
      SPECIAL: ctl.reg_dst = 1'b1;
      default: ctl.reg_dst = 1'b0;
    endcase

    case (instr.r_fmt.op)
      J, JAL: ctl.jump = JMP_IMM;
      SPECIAL: ctl.jump = (instr.r_fmt.funct == FN_JR) ? JMP_REG : JMP_NONE;
      default: ctl.jump = JMP_NONE;
    endcase

    case (instr.r_fmt.op)
      BEQ: ctl.bcu_op = BCU_EQ;
      BNE: ctl.bcu_op = BCU_NE;
      default: ctl.bcu_op = BCU_NONE;
    endcase

    ctl.mem_to_reg = (instr.i_fmt.op == LW);
    ctl.mem_write = (instr.i_fmt.op == SW);
    ctl.zero_ext = (instr.i_fmt.op == ORI);
    ctl.load_upper = (instr.i_fmt.op == LUI);

    case (instr.r_fmt.op)
      SPECIAL: ctl.reg_write = (instr.r_fmt.funct != FN_JR);
      JAL, ADDI, ADDIU, ORI, LW, LUI: ctl.reg_write = 1'b1;
      default: ctl.reg_write = 1'b0;
    endcase

    case (instr.i_fmt.op)
      ADDI, ADDIU, ORI, LW, SW, LUI: ctl.alu_src = 1'b1;
      default: ctl.alu_src = 1'b0;
    endcase

    case (instr.r_fmt.op)
      ADDI, ADDIU, LW, SW: ctl.alu_op = ALU_ADD;
      ORI: ctl.alu_op = ALU_OR;
      LUI: ctl.alu_op = ALU_LUI;
      SPECIAL: begin
        case (instr.r_fmt.funct)
          FN_SUB: ctl.alu_op = ALU_SUB;
          FN_AND: ctl.alu_op = ALU_AND;
          FN_OR: ctl.alu_op = ALU_OR;
          FN_SLT: ctl.alu_op = ALU_SLT;
          default: ctl.alu_op = ALU_ADD;
        endcase
      end
      default: ctl.alu_op = ALU_ADD;
    endcase

    // undefined codes retire as a no-op
    if (!op_ok) begin
      ctl.reg_write = 1'b0;
      ctl.mem_write = 1'b0;
      ctl.jump = JMP_NONE;
    end
  end

endmodule

// File: logic/fetch_unit.sv
`include "mips_config.svh"

module fetch_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,
  input  logic                load_en,
  input  logic [`IMEM_AW-1:0] load_addr,
  input  logic [31:0]         load_data,
  ctrl_if.fetch               ctl,
  input  logic [31:0]         rs_data,
  input  logic [31:0]         rt_data,
  output mips_pkg::instr_t    instr,
  output logic [31:0]         pc,
  output logic [31:0]         pc_plus4
);
  import mips_pkg::*;

  logic [31:0] imem [2**`IMEM_AW];
  logic        br_taken;
  logic        jump_imm;
  logic [31:0] br_target;
  logic [31:0] jmp_target;
  logic [31:0] next_pc;

  // program load only while the core is halted
  always_ff @(posedge clk) begin
    if (load_en && !run) begin
      imem[load_addr] <= load_data;
    end
  end

  assign instr = imem[pc[`IMEM_AW+1:2]];
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctl.bcu_op)
      BCU_EQ: br_taken = (rs_data == rt_data);
      BCU_NE: br_taken = (rs_data != rt_data);
      default: br_taken = 1'b0;
    endcase
  end

  assign br_target = pc_plus4 + {{14{instr.i_fmt.imm[15]}}, instr.i_fmt.imm, 2'b00};
  assign jmp_target = {pc_plus4[31:28], instr.j_fmt.target, 2'b00};
  // jal always takes the region target
  assign jump_imm = (ctl.jump == JMP_IMM) || ctl.jal;

  always_comb begin
    if (jump_imm) begin
      next_pc = jmp_target;
    end else if (ctl.jump == JMP_REG) begin
      next_pc = {rs_data[31:2], 2'b00};
    end else if (br_taken) begin
      next_pc = br_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= next_pc;
    end
  end

endmodule

// File: logic/reg_file.sv
`include "mips_config.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             we,
  input  mips_pkg::instr_t instr,
  input  logic [4:0]       wa,
  input  logic [31:0]      wd,
  output logic [31:0]      rs_data,
  output logic [31:0]      rt_data
);

  logic [31:0] regs [`NUM_REGS];

  // $0 reads as zero
  assign rs_data = (instr.r_fmt.rs == 5'd0) ? '0 : regs[instr.r_fmt.rs];
  assign rt_data = (instr.r_fmt.rt == 5'd0) ? '0 : regs[instr.r_fmt.rt];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

endmodule

// File: logic/alu.sv
module alu (
  input  mips_pkg::alu_op_e op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  output logic [31:0]       result
);
  import mips_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR: result = a | b;
      // signed compare
      ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      ALU_LUI: result = {b[15:0], 16'b0};
      default: result = a + b;
    endcase
  end

endmodule

// File: logic/data_mem.sv
`include "mips_config.svh"

module data_mem (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                we,
  input  logic [`DMEM_AW-1:0] addr,
  input  logic [31:0]         wdata,
  output logic [31:0]         rdata
);

  logic [31:0] mem [2**`DMEM_AW];

  assign rdata = mem[addr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**`DMEM_AW; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[addr] <= wdata;
    end
  end

endmodule

// File: logic/mips_core.sv
`include "mips_config.svh"

module mips_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,
  input  logic                load_en,
  input  logic [`IMEM_AW-1:0] load_addr,
  input  logic [31:0]         load_data,
  output logic                retire,
  output logic [31:0]         retire_pc,
  output logic                wb_en,
  output logic [4:0]          wb_reg,
  output logic [31:0]         wb_data,
  output logic                st_en,
  output logic [`DMEM_AW-1:0] st_addr,
  output logic [31:0]         st_data
);
  import mips_pkg::*;

  instr_t      instr;
  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] imm_ext;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [31:0] mem_rdata;
  logic [4:0]  wa;
  logic [31:0] wd;
  logic        rf_we;
  logic        dm_we;

  ctrl_if ctl ();

  control_unit u_ctrl (.instr(instr), .ctl(ctl));

  fetch_unit u_fetch (
    .clk(clk), .rst_n(rst_n), .run(run),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .ctl(ctl), .rs_data(rs_data), .rt_data(rt_data),
    .instr(instr), .pc(pc), .pc_plus4(pc_plus4)
  );

  reg_file u_rf (
    .clk(clk), .rst_n(rst_n), .we(rf_we), .instr(instr),
    .wa(wa), .wd(wd), .rs_data(rs_data), .rt_data(rt_data)
  );

  assign imm_ext = ctl.zero_ext ? {16'b0, instr.i_fmt.imm}
                                : {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
  // lui ignores rs
  assign alu_a = ctl.load_upper ? '0 : rs_data;
  assign alu_b = ctl.alu_src ? imm_ext : rt_data;

  alu u_alu (.op(ctl.alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

  assign dm_we = run && ctl.mem_write;

  data_mem u_dmem (
    .clk(clk), .rst_n(rst_n), .we(dm_we),
    .addr(alu_result[`DMEM_AW+1:2]), .wdata(rt_data), .rdata(mem_rdata)
  );

  assign wa = ctl.jal ? 5'd31 : (ctl.reg_dst ? instr.r_fmt.rd : instr.r_fmt.rt);
  assign wd = ctl.jal ? pc_plus4 : (ctl.mem_to_reg ? mem_rdata : alu_result);
  assign rf_we = run && ctl.reg_write;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire <= 1'b0;
      wb_en <= 1'b0;
      st_en <= 1'b0;
    end else begin
      retire <= run;
      wb_en <= rf_we && (wa != 5'd0);
      st_en <= dm_we;
    end
  end

  // retire payload, qualified by the enables above
  always_ff @(posedge clk) begin
    retire_pc <= pc;
    wb_reg <= wa;
    wb_data <= wd;
    st_addr <= alu_result[`DMEM_AW+1:2];
    st_data <= rt_data;
  end

endmodule

// File: testbench/mips_core_sva.sv
module mips_core_sva (
  input logic       clk,
  input logic       rst_n,
  input logic       run,
  input logic       retire,
  input logic       wb_en,
  input logic       st_en,
  input logic [4:0] wb_reg
);
  timeunit 1ns;
  timeprecision 1ps;

  // one retire per cycle of run, one cycle late
  retire_after_run: assert property (
    @(posedge clk) disable iff (!rst_n) retire |-> $past(run)
  ) else $error("retire without run in the previous cycle");

  enables_need_retire: assert property (
    @(posedge clk) disable iff (!rst_n) (wb_en || st_en) |-> retire
  ) else $error("wb_en or st_en without retire");

  no_write_to_zero: assert property (
    @(posedge clk) disable iff (!rst_n) wb_en |-> (wb_reg != 5'd0)
  ) else $error("wb_en reported for register 0");

  quiet_after_reset: assert property (
    @(posedge clk) !rst_n |=> (!retire && !wb_en && !st_en)
  ) else $error("retire outputs not cleared by reset");

endmodule

bind mips_core mips_core_sva u_sva (.*);

// File: testbench/mips_checker.sv
`include "mips_config.svh"

module mips_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                run,
  input logic                load_en,
  input logic [`IMEM_AW-1:0] load_addr,
  input logic [31:0]         load_data,
  input logic                retire,
  input logic [31:0]         retire_pc,
  input logic                wb_en,
  input logic [4:0]          wb_reg,
  input logic [31:0]         wb_data,
  input logic                st_en,
  input logic [`DMEM_AW-1:0] st_addr,
  input logic [31:0]         st_data
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RETIRE_LIMIT = 4;

  logic [31:0]         prog [2**`IMEM_AW];
  logic [31:0]         regs [32];
  logic [31:0]         dmem [2**`DMEM_AW];
  logic [31:0]         pc;
  // expected retire, formed at the committing edge
  logic                exp_valid = 1'b0;
  logic [31:0]         exp_pc;
  logic                exp_wb;
  logic [4:0]          exp_reg;
  logic [31:0]         exp_data;
  logic                exp_st;
  logic [`DMEM_AW-1:0] exp_saddr;
  logic [31:0]         exp_sdata;
  int                  errors = 0;
  int                  checks = 0;
  int                  timeouts = 0;
  int                  miss_cnt = 0;

  task automatic reset_model();
    int i;
    pc = '0;
    for (i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (i = 0; i < 2**`DMEM_AW; i++) begin
      dmem[i] = '0;
    end
  endtask

  task automatic write_reg(input logic [4:0] r, input logic [31:0] v);
    exp_wb = (r != 5'd0);
    exp_reg = r;
    exp_data = v;
    if (r != 5'd0) begin
      regs[r] = v;
    end
  endtask

  // one instruction of the reference ISA
  task automatic step_model();
    logic [31:0]         w;
    logic [31:0]         a;
    logic [31:0]         b;
    logic [31:0]         simm;
    logic [31:0]         sum;
    logic [31:0]         npc;
    logic [`DMEM_AW-1:0] daddr;
    w = prog[pc[`IMEM_AW+1:2]];
    a = regs[w[25:21]];
    b = regs[w[20:16]];
    simm = {{16{w[15]}}, w[15:0]};
    sum = a + simm;
    daddr = sum[`DMEM_AW+1:2];
    npc = pc + 32'd4;
    exp_pc = pc;
    exp_wb = 1'b0;
    exp_st = 1'b0;
    case (w[31:26])
      6'h00: begin
        case (w[5:0])
          6'h20: write_reg(w[15:11], a + b);
          6'h22: write_reg(w[15:11], a - b);
          6'h24: write_reg(w[15:11], a & b);
          6'h25: write_reg(w[15:11], a | b);
          6'h2a: write_reg(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
          6'h08: npc = {a[31:2], 2'b00};
          default: ;
        endcase
      end
      6'h02: npc = {npc[31:28], w[25:0], 2'b00};
      6'h03: begin
        write_reg(5'd31, npc);
        npc = {npc[31:28], w[25:0], 2'b00};
      end
      6'h04: if (a == b) npc = npc + (simm << 2);
      6'h05: if (a != b) npc = npc + (simm << 2);
      6'h08, 6'h09: write_reg(w[20:16], sum);
      6'h0d: write_reg(w[20:16], a | {16'b0, w[15:0]});
      6'h0f: write_reg(w[20:16], {w[15:0], 16'b0});
      6'h23: write_reg(w[20:16], dmem[daddr]);
      6'h2b: begin
        dmem[daddr] = b;
        exp_st = 1'b1;
        exp_saddr = daddr;
        exp_sdata = b;
      end
      default: ;
    endcase
    pc = npc;
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s at pc %h: expected %h actual %h", name, exp_pc, exp, act);
    end
  endtask

  always @(posedge clk) begin
    if (load_en && !run) begin
      prog[load_addr] = load_data;
    end
    if (!rst_n) begin
      reset_model();
      exp_valid = 1'b0;
    end else if (run) begin
      step_model();
      exp_valid = 1'b1;
    end else begin
      exp_valid = 1'b0;
    end
  end

  // outputs are stable mid-cycle
  always @(negedge clk) begin
    compare_field("retire", 32'(exp_valid), 32'(retire));
    if (exp_valid) begin
      compare_field("retire_pc", exp_pc, retire_pc);
      compare_field("wb_en", 32'(exp_wb), 32'(wb_en));
      if (exp_wb) begin
        compare_field("wb_reg", 32'(exp_reg), 32'(wb_reg));
        compare_field("wb_data", exp_data, wb_data);
      end
      compare_field("st_en", 32'(exp_st), 32'(st_en));
      if (exp_st) begin
        compare_field("st_addr", 32'(exp_saddr), 32'(st_addr));
        compare_field("st_data", exp_sdata, st_data);
      end
    end
    if (exp_valid && !retire) begin
      miss_cnt++;
    end else begin
      miss_cnt = 0;
    end
    if (miss_cnt == RETIRE_LIMIT) begin
      timeouts++;
      $display("retire timeout: no retire for %0d cycles while running", RETIRE_LIMIT);
    end
  end

endmodule

// File: testbench/tb_mips_core.sv
`include "mips_config.svh"

module tb_mips_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RUN_CYCLES = 200;
  localparam int DRAIN_LIMIT = 20;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                run;
  logic                load_en;
  logic [`IMEM_AW-1:0] load_addr;
  logic [31:0]         load_data;
  logic                retire;
  logic [31:0]         retire_pc;
  logic                wb_en;
  logic [4:0]          wb_reg;
  logic [31:0]         wb_data;
  logic                st_en;
  logic [`DMEM_AW-1:0] st_addr;
  logic [31:0]         st_data;
  logic [31:0]         prog [2**`IMEM_AW];
  int                  seed;
  int                  tb_timeouts;
  int                  total_timeouts;

  mips_core UUT (.*);

  mips_checker u_checker (.*);

  always #4 clk = ~clk;

  function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] fn);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // registers $0 to $7 only, so results feed each other
  task automatic build_program();
    int          i;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [15:0] off;
    for (i = 0; i < 2**`IMEM_AW; i++) begin
      rs = 5'(pick(8));
      rt = 5'(pick(8));
      rd = 5'(pick(8));
      imm = 16'($random(seed));
      off = 16'(pick(9) - 3);
      case (pick(18))
        0: prog[i] = r_word(rs, rt, rd, 6'h20);
        1: prog[i] = r_word(rs, rt, rd, 6'h22);
        2: prog[i] = r_word(rs, rt, rd, 6'h24);
        3: prog[i] = r_word(rs, rt, rd, 6'h25);
        4: prog[i] = r_word(rs, rt, rd, 6'h2a);
        5: prog[i] = r_word((pick(2) == 0) ? 5'd31 : rs, 5'd0, 5'd0, 6'h08);
        6: prog[i] = {6'h02, 26'(pick(2**`IMEM_AW))};
        7: prog[i] = {6'h03, 26'(pick(2**`IMEM_AW))};
        8: prog[i] = i_word(6'h04, rs, rt, off);
        9: prog[i] = i_word(6'h05, rs, rt, off);
        10: prog[i] = i_word(6'h08, rs, rt, imm);
        11: prog[i] = i_word(6'h09, rs, rt, imm);
        12: prog[i] = i_word(6'h0d, rs, rt, imm);
        13: prog[i] = i_word(6'h23, rs, rt, imm);
        14: prog[i] = i_word(6'h2b, rs, rt, imm);
        15: prog[i] = i_word(6'h0f, rs, rt, imm);
        16: prog[i] = i_word((pick(2) == 0) ? 6'h3c : 6'h11, rs, rt, imm);
        default: prog[i] = r_word(rs, rt, rd, (pick(2) == 0) ? 6'h21 : 6'h27);
      endcase
    end
  endtask

  // a stray load halfway through must be ignored
  task automatic run_cycles(input int n);
    int i;
    run = 1'b1;
    for (i = 0; i < n; i++) begin
      @(negedge clk);
      load_en = (i == n / 2);
      load_addr = '0;
      load_data = 32'hffff_ffff;
    end
    run = 1'b0;
    load_en = 1'b0;
  endtask

  task automatic wait_retire_low();
    int n;
    n = 0;
    while (retire !== 1'b0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (retire !== 1'b0) begin
      tb_timeouts++;
      $display("timeout: retire still high %0d cycles after run was dropped", n);
    end
  endtask

  initial begin
    int i;
    rst_n = 1'b0;
    run = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    seed = 3505;
    tb_timeouts = 0;
    build_program();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < 2**`IMEM_AW; i++) begin
      load_en = 1'b1;
      load_addr = `IMEM_AW'(i);
      load_data = prog[i];
      @(negedge clk);
    end
    load_en = 1'b0;
    @(negedge clk);
    run_cycles(RUN_CYCLES);
    wait_retire_low();
    // paused, then resumed at the same pc
    repeat (10) @(negedge clk);
    run_cycles(RUN_CYCLES);
    wait_retire_low();
    repeat (2) @(negedge clk);
    total_timeouts = u_checker.timeouts + tb_timeouts;
    $display("errors: %0d  checks: %0d  timeouts: %0d",
             u_checker.errors, u_checker.checks, total_timeouts);
    if (u_checker.errors == 0 && total_timeouts == 0 && u_checker.checks > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+logic
logic/mips_pkg.sv
logic/ctrl_if.sv
logic/control_unit.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/alu.sv
logic/data_mem.sv
logic/mips_core.sv
testbench/mips_core_sva.sv
testbench/mips_checker.sv
testbench/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_mips_core -f sim.f --Mdir obj_dir

./obj_dir/Vtb_mips_core > sim.log 2>&1 || true
cat sim.log

if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
exit 1
